/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMM_W       = 16;
    localparam int IMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    // R-type function codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    imm_b;
        logic    shamt_a;
        logic    reg_write;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [XLEN-1:0]       imm;
    } dec_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       result;
    } wb_t;

endpackage

`default_nettype wire

/* decode/decode_unit.sv */
`default_nettype none

module decode_unit (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire  mips_pkg::fetch_t             i_fetch,
    input  wire  [mips_pkg::XLEN-1:0]          i_rs_data,
    input  wire  [mips_pkg::XLEN-1:0]          i_rt_data,
    output logic [mips_pkg::REG_ADDR_W-1:0]    o_rs_addr,
    output logic [mips_pkg::REG_ADDR_W-1:0]    o_rt_addr,
    output logic                               o_halt_fetch,
    output mips_pkg::dec_ex_t                  o_dec_ex
);
    import mips_pkg::*;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd;
    logic [IMM_W-1:0]      imm16;
    logic [XLEN-1:0]       imm_ext;
    ctrl_t                 ctrl;
    logic                  halt_seen_q;

    assign opcode    = i_fetch.instr[31:26];
    assign o_rs_addr = i_fetch.instr[25:21];
    assign o_rt_addr = i_fetch.instr[20:16];
    assign rd        = i_fetch.instr[15:11];
    assign funct     = i_fetch.instr[5:0];
    assign imm16     = i_fetch.instr[IMM_W-1:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl.alu_op  = ALU_SLL;
                        ctrl.shamt_a = 1'b1;
                    end
                    FN_SRL: begin
                        ctrl.alu_op  = ALU_SRL;
                        ctrl.shamt_a = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: ctrl = '{alu_op: ALU_ADD, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_SLTI:  ctrl = '{alu_op: ALU_SLT, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_ANDI:  ctrl = '{alu_op: ALU_AND, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_ORI:   ctrl = '{alu_op: ALU_OR, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_XORI:  ctrl = '{alu_op: ALU_XOR, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_LUI:   ctrl = '{alu_op: ALU_PASS_B, imm_b: 1'b1, shamt_a: 1'b0,
                               reg_write: 1'b1, halt: 1'b0};
            OP_HALT:  ctrl.halt = 1'b1;
            default:  ;
        endcase
    end

    // Sign extend for arithmetic compares, zero extend for logic ops
    always_comb begin
        case (opcode)
            OP_ADDIU, OP_SLTI: imm_ext = {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
            OP_LUI:            imm_ext = {imm16, {(XLEN-IMM_W){1'b0}}};
            default:           imm_ext = {{(XLEN-IMM_W){1'b0}}, imm16};
        endcase
    end

    assign o_halt_fetch = i_fetch.valid && ctrl.halt && !halt_seen_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            halt_seen_q <= 1'b0;
            o_dec_ex    <= '0;
        end else begin
            if (o_halt_fetch) begin
                halt_seen_q <= 1'b1;
            end
            // Anything behind the halt is squashed here
            o_dec_ex.valid   <= i_fetch.valid && !halt_seen_q;
            o_dec_ex.ctrl    <= ctrl;
            o_dec_ex.rs      <= o_rs_addr;
            o_dec_ex.rt      <= o_rt_addr;
            o_dec_ex.dst     <= (opcode == OP_RTYPE) ? rd : o_rt_addr;
            o_dec_ex.rs_data <= i_rs_data;
            o_dec_ex.rt_data <= i_rt_data;
            o_dec_ex.imm     <= imm_ext;
        end
    end

endmodule

`default_nettype wire

/* decode/register_file.sv */
`default_nettype none

module register_file (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]    i_rs_addr,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]    i_rt_addr,
    input  wire  mips_pkg::wb_t                i_wb,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]    i_dbg_addr,
    output logic [mips_pkg::XLEN-1:0]          o_rs_data,
    output logic [mips_pkg::XLEN-1:0]          o_rt_data,
    output logic [mips_pkg::XLEN-1:0]          o_dbg_data
);
    import mips_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_en;

    assign wr_en = i_wb.valid && i_wb.we && (i_wb.dst != '0);

    // Write-first read so decode sees the value retiring this cycle
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (i_wb.dst == addr)) begin
            data = i_wb.result;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

    assign o_dbg_data = regs[i_dbg_addr];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.dst] <= i_wb.result;
        end
    end

endmodule

`default_nettype wire

/* execute/execute_unit.sv */
`default_nettype none

module execute_unit (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire  mips_pkg::dec_ex_t            i_dec_ex,
    output mips_pkg::wb_t                      o_wb,
    output logic                               o_halted
);
    import mips_pkg::*;

    logic            fwd_rs;
    logic            fwd_rt;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            halt_wb_q;

    // Forward from the result registered last cycle
    assign fwd_rs = o_wb.valid && o_wb.we && (o_wb.dst == i_dec_ex.rs) && (i_dec_ex.rs != '0);
    assign fwd_rt = o_wb.valid && o_wb.we && (o_wb.dst == i_dec_ex.rt) && (i_dec_ex.rt != '0);

    assign rs_val = fwd_rs ? o_wb.result : i_dec_ex.rs_data;
    assign rt_val = fwd_rt ? o_wb.result : i_dec_ex.rt_data;

    // Shift amount sits in bits 10:6 of the zero-extended low half
    assign alu_a = i_dec_ex.ctrl.shamt_a ? {{(XLEN-5){1'b0}}, i_dec_ex.imm[10:6]} : rs_val;
    assign alu_b = i_dec_ex.ctrl.imm_b ? i_dec_ex.imm : rt_val;

    always_comb begin
        case (i_dec_ex.ctrl.alu_op)
            ALU_ADD:    alu_y = alu_a + alu_b;
            ALU_SUB:    alu_y = alu_a - alu_b;
            ALU_AND:    alu_y = alu_a & alu_b;
            ALU_OR:     alu_y = alu_a | alu_b;
            ALU_XOR:    alu_y = alu_a ^ alu_b;
            ALU_NOR:    alu_y = ~(alu_a | alu_b);
            ALU_SLT:    alu_y = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLL:    alu_y = alu_b << alu_a[4:0];
            ALU_SRL:    alu_y = alu_b >> alu_a[4:0];
            ALU_PASS_B: alu_y = alu_b;
            default:    alu_y = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb      <= '0;
            halt_wb_q <= 1'b0;
            o_halted  <= 1'b0;
        end else begin
            o_wb.valid  <= i_dec_ex.valid;
            o_wb.we     <= i_dec_ex.valid && i_dec_ex.ctrl.reg_write && (i_dec_ex.dst != '0);
            o_wb.dst    <= i_dec_ex.dst;
            o_wb.result <= alu_y;
            halt_wb_q   <= i_dec_ex.valid && i_dec_ex.ctrl.halt;
            // Sticky until reset
            if (halt_wb_q) begin
                o_halted <= 1'b1;
            end
        end
    end

    a_no_write_to_r0: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (o_wb.valid && o_wb.we) |-> (o_wb.dst != '0)
    );

endmodule

`default_nettype wire

/* mips_core.f */
common/mips_pkg.sv
src/instr_mem.sv
src/fetch_unit.sv
decode/decode_unit.sv
decode/register_file.sv
execute/execute_unit.sv
src/mips_core_top.sv
verif/tb_clock_gen.sv
verif/mips_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the MIPS core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f mips_core.f --top-module mips_core_tb -o mips_core_sim

./obj_dir/mips_core_sim | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

/* src/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_fetch_grant,
    input  wire  [mips_pkg::XLEN-1:0]          i_fetch_word,
    input  wire                                i_halt_fetch,
    output logic [mips_pkg::IMEM_ADDR_W-1:0]   o_fetch_addr,
    output mips_pkg::fetch_t                   o_fetch,
    output logic [mips_pkg::XLEN-1:0]          o_pc
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] req_pc_q;
    logic            req_valid_q;
    logic            halt_q;

    // Byte PC to word address
    assign o_fetch_addr = pc_q[IMEM_ADDR_W+1:2];
    assign o_pc         = pc_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q        <= '0;
            req_valid_q <= 1'b0;
            halt_q      <= 1'b0;
        end else begin
            if (i_halt_fetch) begin
                halt_q <= 1'b1;
            end
            req_valid_q <= i_fetch_grant && !halt_q;
            if (i_fetch_grant && !halt_q) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fetch_grant) begin
            req_pc_q <= pc_q;
        end
    end

    // Word arrives from memory one cycle after the request
    always_comb begin
        o_fetch.valid = req_valid_q && !halt_q;
        o_fetch.pc    = req_pc_q;
        o_fetch.instr = i_fetch_word;
    end

    a_pc_frozen_after_halt: assert property (
        @(posedge i_clk) disable iff (i_reset)
        halt_q |=> $stable(pc_q)
    );

endmodule

`default_nettype wire

/* src/instr_mem.sv */
`default_nettype none

module instr_mem (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_load_en,
    input  wire  [mips_pkg::IMEM_ADDR_W-1:0]   i_load_addr,
    input  wire  [mips_pkg::XLEN-1:0]          i_load_data,
    input  wire  [mips_pkg::IMEM_ADDR_W-1:0]   i_fetch_addr,
    output logic                               o_fetch_grant,
    output logic [mips_pkg::XLEN-1:0]          o_fetch_word
);
    import mips_pkg::*;

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Loader always wins the single port
    assign o_fetch_grant = !i_load_en && !i_reset;

    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_data;
        end
        if (o_fetch_grant) begin
            o_fetch_word <= mem[i_fetch_addr];
        end
    end

    a_no_grant_during_load: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_load_en |-> !o_fetch_grant
    );

endmodule

`default_nettype wire

/* src/mips_core_top.sv */
`default_nettype none

module mips_core_top (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_load_en,
    input  wire  [mips_pkg::IMEM_ADDR_W-1:0]   i_load_addr,
    input  wire  [mips_pkg::XLEN-1:0]          i_load_data,
    input  wire  [mips_pkg::REG_ADDR_W-1:0]    i_dbg_reg_addr,
    output wire  [mips_pkg::XLEN-1:0]          o_dbg_reg_data,
    output wire  [mips_pkg::XLEN-1:0]          o_pc,
    output wire                                o_halted
);
    import mips_pkg::*;

    wire [IMEM_ADDR_W-1:0] fetch_addr;
    wire                   fetch_grant;
    wire [XLEN-1:0]        fetch_word;
    wire                   halt_fetch;
    fetch_t                if_id;
    dec_ex_t               id_ex;
    wb_t                   ex_wb;
    wire [REG_ADDR_W-1:0]  rs_addr;
    wire [REG_ADDR_W-1:0]  rt_addr;
    wire [XLEN-1:0]        rs_data;
    wire [XLEN-1:0]        rt_data;

    instr_mem u_instr_mem (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_load_en      (i_load_en),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data),
        .i_fetch_addr   (fetch_addr),
        .o_fetch_grant  (fetch_grant),
        .o_fetch_word   (fetch_word)
    );

    fetch_unit u_fetch (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_fetch_grant  (fetch_grant),
        .i_fetch_word   (fetch_word),
        .i_halt_fetch   (halt_fetch),
        .o_fetch_addr   (fetch_addr),
        .o_fetch        (if_id),
        .o_pc           (o_pc)
    );

    decode_unit u_decode (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_fetch        (if_id),
        .i_rs_data      (rs_data),
        .i_rt_data      (rt_data),
        .o_rs_addr      (rs_addr),
        .o_rt_addr      (rt_addr),
        .o_halt_fetch   (halt_fetch),
        .o_dec_ex       (id_ex)
    );

    register_file u_regfile (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rs_addr      (rs_addr),
        .i_rt_addr      (rt_addr),
        .i_wb           (ex_wb),
        .i_dbg_addr     (i_dbg_reg_addr),
        .o_rs_data      (rs_data),
        .o_rt_data      (rt_data),
        .o_dbg_data     (o_dbg_reg_data)
    );

    execute_unit u_execute (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_dec_ex       (id_ex),
        .o_wb           (ex_wb),
        .o_halted       (o_halted)
    );

endmodule

`default_nettype wire

/* verif/mips_core_tb.sv */
`default_nettype none

module mips_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int NUM_PROGS  = 8;
    localparam int BODY_LEN   = 24;
    localparam int TRAIL_LEN  = 4;
    localparam int PROG_LEN   = 14 + BODY_LEN + 1 + TRAIL_LEN;
    localparam int HALT_LIMIT = PROG_LEN + 50;
    localparam int WATCHDOG_CYCLES = NUM_PROGS * (PROG_LEN + IMEM_DEPTH + 50);

    localparam logic [5:0] FN_LIST [9] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                           FN_NOR, FN_SLT, FN_SLL, FN_SRL};
    localparam logic [5:0] OP_LIST [6] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
                                           OP_SLTI, OP_LUI};

    logic                   clk;
    logic                   reset;
    logic                   load_en;
    logic [IMEM_ADDR_W-1:0] load_addr;
    logic [XLEN-1:0]        load_data;
    logic [REG_ADDR_W-1:0]  dbg_addr;
    wire  [XLEN-1:0]        dbg_data;
    wire  [XLEN-1:0]        pc;
    wire                    halted;

    logic [15:0] lfsr_state;
    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_regs [32];
    int          errors;
    int          checks;

    tb_clock_gen #(.PERIOD_NS(4)) u_clk_gen (.o_clk(clk));

    mips_core_top DUT (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_load_en      (load_en),
        .i_load_addr    (load_addr),
        .i_load_data    (load_data),
        .i_dbg_reg_addr (dbg_addr),
        .o_dbg_reg_data (dbg_data),
        .o_pc           (pc),
        .o_halted       (halted)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt,
                                          input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // Mix 0 gives R-type only, 1 immediates only, 2 either
    task automatic random_instr(input int mix, input logic [4:0] rs, input logic [4:0] rt,
                                input logic [4:0] dst, output logic [31:0] w);
        logic [31:0] pick;
        logic [31:0] imm;
        logic [31:0] sel;
        rand_bits(1, pick);
        rand_bits(16, imm);
        rand_bits(4, sel);
        if (mix == 0 || (mix == 2 && pick[0])) begin
            w = enc_r(rs, rt, dst, imm[10:6], FN_LIST[4'(sel % 9)]);
        end else begin
            w = enc_i(OP_LIST[3'(sel % 6)], rs, dst, imm[15:0]);
        end
    endtask

    // Kinds: 0 R-type, 1 immediate, 2 dependent chain, 3 chain with r0 targets
    task automatic build_program(input int kind);
        logic [31:0] v;
        logic [31:0] hi;
        logic [31:0] w;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        int          idx;
        idx = 0;
        // Seed r1..r7 with full-width values
        for (int r = 1; r < 8; r++) begin
            rand_bits(16, hi);
            rand_bits(16, v);
            prog[idx]     = enc_i(OP_LUI, 5'd0, 5'(r), hi[15:0]);
            prog[idx + 1] = enc_i(OP_ORI, 5'(r), 5'(r), v[15:0]);
            idx += 2;
        end
        prev1 = 5'd7;
        prev2 = 5'd6;
        for (int i = 0; i < BODY_LEN + 1 + TRAIL_LEN; i++) begin
            rand_bits(4, v);
            rs = 5'(v);
            rand_bits(4, v);
            rt = 5'(v);
            rand_bits(4, v);
            dst = 5'(v);
            if (kind >= 2) begin
                rand_bits(1, v);
                rs = v[0] ? prev1 : prev2;
                rt = v[0] ? prev2 : prev1;
            end
            if (kind == 3) begin
                rand_bits(1, v);
                if (v[0]) begin
                    dst = 5'd0;
                end
            end
            if (i == BODY_LEN) begin
                rand_bits(26, v);
                w = {OP_HALT, v[25:0]};
            end else begin
                random_instr((kind > 2) ? 2 : kind, rs, rt, dst, w);
            end
            prog[idx] = w;
            idx++;
            prev2 = prev1;
            prev1 = dst;
        end
    endtask

    // Sequential ISA model, stops at the first halt
    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w = prog[i];
            if (w[31:26] == OP_HALT) begin
                break;
            end
            a     = model_regs[w[25:21]];
            b     = model_regs[w[20:16]];
            imm_s = {{16{w[15]}}, w[15:0]};
            imm_z = {16'h0000, w[15:0]};
            dst   = w[20:16];
            wr    = 1'b1;
            res   = '0;
            case (w[31:26])
                OP_RTYPE: begin
                    dst = w[15:11];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << w[10:6];
                        FN_SRL:  res = b >> w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + imm_s;
                OP_SLTI:  res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                OP_ANDI:  res = a & imm_z;
                OP_ORI:   res = a | imm_z;
                OP_XORI:  res = a ^ imm_z;
                OP_LUI:   res = {w[15:0], 16'h0000};
                default:  wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                model_regs[dst] = res;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset   = 1'b1;
        load_en = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_value("o_halted", 32'(halted), 32'd0);
            check_value("o_pc", pc, 32'd0);
        end
        reset = 1'b0;
    endtask

    // Loader starts on the same edge that releases reset
    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            load_en   = 1'b1;
            load_addr = IMEM_ADDR_W'(i);
            load_data = prog[i];
            @(negedge clk);
            check_value("o_pc", pc, 32'd0);
            check_value("o_halted", 32'(halted), 32'd0);
        end
        load_en = 1'b0;
    endtask

    task automatic run_program(input int num, input int kind);
        logic [31:0] halt_pc;
        int          cycles;
        build_program(kind);
        run_model();
        apply_reset();
        load_program();
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (halted) else begin
            errors++;
            $display("Program %0d never halted within %0d cycles after loading",
                     num, HALT_LIMIT);
        end
        if (halted) begin
            halt_pc = pc;
            for (int r = 0; r < 32; r++) begin
                dbg_addr = 5'(r);
                @(negedge clk);
                check_value($sformatf("o_dbg_reg_data[r%0d]", r), dbg_data, model_regs[r]);
                check_value("o_pc", pc, halt_pc);
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        dbg_addr   = '0;
        lfsr_state = 16'd92;
        errors     = 0;
        checks     = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p, p % 4);
        end
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the programs did not all finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire
